// File: design/memTypesPkg.sv
package memTypesPkg;

    // Word and byte-address widths
    localparam int dataWidth = 32;
    localparam int addrWidth = 32;

    typedef logic [dataWidth-1:0] Data;
    typedef logic [addrWidth-1:0] Addr;

    // Access size of a load or store
    typedef enum logic [1:0] {
        DataAccess_Byte = 2'b00,
        DataAccess_Half = 2'b01,
        DataAccess_Word = 2'b10
    } DataAccess;

endpackage

// File: design/arbTypesPkg.sv
package arbTypesPkg;

    // Masters that share the data memory
    typedef enum logic {
        MasterPort_Cpu = 1'b0,
        MasterPort_Dma = 1'b1
    } MasterPort;

endpackage

// File: design/dataBus.sv
`timescale 1ns/1ps

interface dataBus;

    memTypesPkg::Addr       addr;
    memTypesPkg::DataAccess access;
    logic                   unsignedLoad;
    logic                   wr;
    logic                   rd;
    memTypesPkg::Data       wrData;
    memTypesPkg::Data       rdData;

    modport master (
        output addr, access, unsignedLoad, wr, rd, wrData,
        input  rdData
    );

    modport slave (
        input  addr, access, unsignedLoad, wr, rd, wrData,
        output rdData
    );

endinterface

// File: design/ramByteLane.sv
`timescale 1ns/1ps

module ramByteLane #(
    parameter int memWords = 1024
) (
    input  logic                        clock,
    input  logic [$clog2(memWords)-1:0] index,
    input  logic                        wren,
    input  logic [7:0]                  data,
    output logic [7:0]                  q
);

    logic [7:0] mem [memWords];

    // Registered read returns old contents on a same-index write
    always_ff @(posedge clock) begin
        if (wren) begin
            mem[index] <= data;
        end
        q <= mem[index];
    end

endmodule

// File: design/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
    parameter int memWords = 1024
) (
    input logic   clock,
    input logic   rstN,
    dataBus.slave bus
);

    localparam int indexWidth = $clog2(memWords);
    localparam int dataWidth = memTypesPkg::dataWidth;

    logic [3:0][7:0] laneData;
    logic [3:0][7:0] laneQ;
    logic [3:0]      we;

    memTypesPkg::DataAccess rdAccess;
    logic [1:0]             rdOffset;
    logic                   rdUnsigned;

    logic [7:0]  selByte;
    logic [15:0] selHalf;

    // Store data replicated so every lane sees its own bytes
    always_comb begin
        unique case (bus.access)
            memTypesPkg::DataAccess_Byte: laneData = {4{bus.wrData[7:0]}};
            memTypesPkg::DataAccess_Half: laneData = {2{bus.wrData[15:0]}};
            default:                      laneData = bus.wrData;
        endcase
    end

    // Lane enables from size and low address bits
    always_comb begin
        unique casez ({bus.access, bus.addr[1:0]})
            {memTypesPkg::DataAccess_Byte, 2'b00}: we = 4'b0001;
            {memTypesPkg::DataAccess_Byte, 2'b01}: we = 4'b0010;
            {memTypesPkg::DataAccess_Byte, 2'b10}: we = 4'b0100;
            {memTypesPkg::DataAccess_Byte, 2'b11}: we = 4'b1000;
            {memTypesPkg::DataAccess_Half, 2'b0?}: we = 4'b0011;
            {memTypesPkg::DataAccess_Half, 2'b1?}: we = 4'b1100;
            {memTypesPkg::DataAccess_Word, 2'b??}: we = 4'b1111;
            default:                               we = 4'b0000;
        endcase
    end

    for (genvar lane = 0; lane < 4; lane++) begin : gLane
        ramByteLane #(
            .memWords (memWords)
        ) ram (
            .clock (clock),
            .index (bus.addr[indexWidth+1:2]),
            .wren  (we[lane] & bus.wr),
            .data  (laneData[lane]),
            .q     (laneQ[lane])
        );
    end

    // Load format kept until the lanes deliver
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            rdAccess   <= memTypesPkg::DataAccess_Word;
            rdOffset   <= 2'b00;
            rdUnsigned <= 1'b0;
        end else if (bus.rd) begin
            rdAccess   <= bus.access;
            rdOffset   <= bus.addr[1:0];
            rdUnsigned <= bus.unsignedLoad;
        end
    end

    assign selByte = laneQ[rdOffset];
    assign selHalf = rdOffset[1] ? laneQ[3:2] : laneQ[1:0];

    // Shift down and extend
    always_comb begin
        unique case (rdAccess)
            memTypesPkg::DataAccess_Byte:
                bus.rdData = {{(dataWidth-8){~rdUnsigned & selByte[7]}}, selByte};
            memTypesPkg::DataAccess_Half:
                bus.rdData = {{(dataWidth-16){~rdUnsigned & selHalf[15]}}, selHalf};
            default:
                bus.rdData = laneQ;
        endcase
    end

endmodule

// File: design/busArbiter.sv
`timescale 1ns/1ps

module busArbiter (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   cpuRd,
    input  logic                   cpuWr,
    input  logic                   dmaRd,
    input  logic                   dmaWr,
    input  memTypesPkg::Addr       cpuAddr,
    input  memTypesPkg::Addr       dmaAddr,
    input  memTypesPkg::DataAccess cpuAccess,
    input  memTypesPkg::DataAccess dmaAccess,
    input  logic                   cpuUnsigned,
    input  logic                   dmaUnsigned,
    input  memTypesPkg::Data       cpuWrData,
    input  memTypesPkg::Data       dmaWrData,
    output logic                   cpuGrant,
    output logic                   dmaGrant,
    output memTypesPkg::Data       cpuRdData,
    output memTypesPkg::Data       dmaRdData,
    output logic                   cpuRdValid,
    output logic                   dmaRdValid,
    dataBus.master                 mem
);

    arbTypesPkg::MasterPort lastWinner;
    arbTypesPkg::MasterPort winner;
    arbTypesPkg::MasterPort rdOwner;

    logic cpuReq;
    logic dmaReq;
    logic rdPending;

    assign cpuReq = cpuRd | cpuWr;
    assign dmaReq = dmaRd | dmaWr;

    // Round robin where the loser of the last contest goes first
    always_comb begin
        winner = arbTypesPkg::MasterPort_Cpu;
        if (cpuReq && dmaReq) begin
            winner = (lastWinner == arbTypesPkg::MasterPort_Cpu) ?
                     arbTypesPkg::MasterPort_Dma : arbTypesPkg::MasterPort_Cpu;
        end else if (dmaReq) begin
            winner = arbTypesPkg::MasterPort_Dma;
        end
    end

    assign cpuGrant = cpuReq && (winner == arbTypesPkg::MasterPort_Cpu);
    assign dmaGrant = dmaReq && (winner == arbTypesPkg::MasterPort_Dma);

    // Winner's fields onto the memory bus
    always_comb begin
        if (winner == arbTypesPkg::MasterPort_Dma) begin
            mem.addr         = dmaAddr;
            mem.access       = dmaAccess;
            mem.unsignedLoad = dmaUnsigned;
            mem.wrData       = dmaWrData;
        end else begin
            mem.addr         = cpuAddr;
            mem.access       = cpuAccess;
            mem.unsignedLoad = cpuUnsigned;
            mem.wrData       = cpuWrData;
        end
    end

    assign mem.rd = (cpuGrant & cpuRd) | (dmaGrant & dmaRd);
    assign mem.wr = (cpuGrant & cpuWr) | (dmaGrant & dmaWr);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            lastWinner <= arbTypesPkg::MasterPort_Dma;
            rdPending  <= 1'b0;
            rdOwner    <= arbTypesPkg::MasterPort_Cpu;
        end else begin
            if (cpuReq || dmaReq) begin
                lastWinner <= winner;
            end
            rdPending <= mem.rd;
            if (mem.rd) begin
                rdOwner <= winner;
            end
        end
    end

    // Read data back to whoever asked for it
    assign cpuRdValid = rdPending && (rdOwner == arbTypesPkg::MasterPort_Cpu);
    assign dmaRdValid = rdPending && (rdOwner == arbTypesPkg::MasterPort_Dma);
    assign cpuRdData  = cpuRdValid ? mem.rdData : '0;
    assign dmaRdData  = dmaRdValid ? mem.rdData : '0;

endmodule

// File: design/sharedDataMemory.sv
`timescale 1ns/1ps

module sharedDataMemory #(
    parameter int memWords = 1024
) (
    input  logic                   clock,
    input  logic                   rstN,

    // Load/store unit
    input  logic                   cpuRd,
    input  logic                   cpuWr,
    input  memTypesPkg::Addr       cpuAddr,
    input  memTypesPkg::DataAccess cpuAccess,
    input  logic                   cpuUnsigned,
    input  memTypesPkg::Data       cpuWrData,
    output logic                   cpuGrant,
    output memTypesPkg::Data       cpuRdData,
    output logic                   cpuRdValid,

    // Block-transfer engine
    input  logic                   dmaRd,
    input  logic                   dmaWr,
    input  memTypesPkg::Addr       dmaAddr,
    input  memTypesPkg::DataAccess dmaAccess,
    input  logic                   dmaUnsigned,
    input  memTypesPkg::Data       dmaWrData,
    output logic                   dmaGrant,
    output memTypesPkg::Data       dmaRdData,
    output logic                   dmaRdValid
);

    dataBus memBus ();

    busArbiter arbiter (
        .clock       (clock),
        .rstN        (rstN),
        .cpuRd       (cpuRd),
        .cpuWr       (cpuWr),
        .dmaRd       (dmaRd),
        .dmaWr       (dmaWr),
        .cpuAddr     (cpuAddr),
        .dmaAddr     (dmaAddr),
        .cpuAccess   (cpuAccess),
        .dmaAccess   (dmaAccess),
        .cpuUnsigned (cpuUnsigned),
        .dmaUnsigned (dmaUnsigned),
        .cpuWrData   (cpuWrData),
        .dmaWrData   (dmaWrData),
        .cpuGrant    (cpuGrant),
        .dmaGrant    (dmaGrant),
        .cpuRdData   (cpuRdData),
        .dmaRdData   (dmaRdData),
        .cpuRdValid  (cpuRdValid),
        .dmaRdValid  (dmaRdValid),
        .mem         (memBus.master)
    );

    dataMemory #(
        .memWords (memWords)
    ) memory (
        .clock (clock),
        .rstN  (rstN),
        .bus   (memBus.slave)
    );

endmodule

// File: verif/sharedDataMemoryTb.sv
`timescale 1ns/1ps

module sharedDataMemoryTb;

    localparam int memWords = 1024;
    localparam int addrBits = $clog2(memWords) + 2;
    localparam int grantTimeout = 20;
    localparam int randomOps = 800;

    logic clock;
    logic rstN;

    // Index 0 is the cpu port, index 1 the dma port
    logic                   rdIn [2];
    logic                   wrIn [2];
    memTypesPkg::Addr       addrIn [2];
    memTypesPkg::DataAccess accIn [2];
    logic                   unsIn [2];
    memTypesPkg::Data       wrDataIn [2];
    logic [1:0]             grant;
    logic [1:0]             rdValid;
    logic [1:0][31:0]       rdData;

    logic [7:0]       model [memWords*4];
    memTypesPkg::Data cpuExpected [$];
    memTypesPkg::Data dmaExpected [$];
    logic [31:0]      lfsr = 32'h569d_b451;

    sharedDataMemory #(
        .memWords (memWords)
    ) i_dut (
        .clock       (clock),
        .rstN        (rstN),
        .cpuRd       (rdIn[0]),
        .cpuWr       (wrIn[0]),
        .cpuAddr     (addrIn[0]),
        .cpuAccess   (accIn[0]),
        .cpuUnsigned (unsIn[0]),
        .cpuWrData   (wrDataIn[0]),
        .cpuGrant    (grant[0]),
        .cpuRdData   (rdData[0]),
        .cpuRdValid  (rdValid[0]),
        .dmaRd       (rdIn[1]),
        .dmaWr       (wrIn[1]),
        .dmaAddr     (addrIn[1]),
        .dmaAccess   (accIn[1]),
        .dmaUnsigned (unsIn[1]),
        .dmaWrData   (wrDataIn[1]),
        .dmaGrant    (grant[1]),
        .dmaRdData   (rdData[1]),
        .dmaRdValid  (rdValid[1])
    );

    initial begin : clockGen
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    // Galois LFSR stepped once per bit
    function automatic logic nextBit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], nextBit()};
        end
        return value;
    endfunction

    function automatic memTypesPkg::Data fillWord(input memTypesPkg::Addr a);
        return (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    // Little endian with bits below the access size ignored
    function automatic memTypesPkg::Data loadRef(input memTypesPkg::Addr a,
            input memTypesPkg::DataAccess acc, input logic uns);
        logic [addrBits-1:0] at;
        logic [7:0]          b;
        logic [15:0]         h;
        memTypesPkg::Data    result;
        at = a[addrBits-1:0];
        b = model[at];
        h = {model[{at[addrBits-1:1], 1'b1}], model[{at[addrBits-1:1], 1'b0}]};
        case (acc)
            memTypesPkg::DataAccess_Byte: result = uns ? {24'b0, b} : {{24{b[7]}}, b};
            memTypesPkg::DataAccess_Half: result = uns ? {16'b0, h} : {{16{h[15]}}, h};
            default: result = {model[{at[addrBits-1:2], 2'b11}], model[{at[addrBits-1:2], 2'b10}],
                               model[{at[addrBits-1:2], 2'b01}], model[{at[addrBits-1:2], 2'b00}]};
        endcase
        return result;
    endfunction

    function automatic void storeRef(input memTypesPkg::Addr a,
            input memTypesPkg::DataAccess acc, input memTypesPkg::Data d);
        logic [addrBits-1:0] at;
        at = a[addrBits-1:0];
        case (acc)
            memTypesPkg::DataAccess_Byte: model[at] = d[7:0];
            memTypesPkg::DataAccess_Half: begin
                model[{at[addrBits-1:1], 1'b0}] = d[7:0];
                model[{at[addrBits-1:1], 1'b1}] = d[15:8];
            end
            default: begin
                model[{at[addrBits-1:2], 2'b00}] = d[7:0];
                model[{at[addrBits-1:2], 2'b01}] = d[15:8];
                model[{at[addrBits-1:2], 2'b10}] = d[23:16];
                model[{at[addrBits-1:2], 2'b11}] = d[31:24];
            end
        endcase
    endfunction

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("error at %0d ns: %s expected %h, got %h",
                                      $time, name, expected, actual));
        end
    endtask

    task automatic dropRequest(input logic m);
        rdIn[m] = 1'b0;
        wrIn[m] = 1'b0;
    endtask

    // Hold the request until granted, then update the model
    task automatic issue(input logic m, input logic isWrite, input memTypesPkg::Addr a,
            input memTypesPkg::DataAccess acc, input logic uns, input memTypesPkg::Data d);
        int waited;
        rdIn[m] = ~isWrite;
        wrIn[m] = isWrite;
        addrIn[m] = a;
        accIn[m] = acc;
        unsIn[m] = uns;
        wrDataIn[m] = d;
        waited = 0;
        @(negedge clock);
        while (!grant[m]) begin
            waited++;
            if (waited > grantTimeout) begin
                stopWithFailure($sformatf("%s request was not granted within %0d cycles",
                                          m ? "dma" : "cpu", grantTimeout));
            end
            @(negedge clock);
        end
        if (isWrite) begin
            storeRef(a, acc, d);
        end else if (m) begin
            dmaExpected.push_back(loadRef(a, acc, uns));
        end else begin
            cpuExpected.push_back(loadRef(a, acc, uns));
        end
        @(posedge clock);
        #1;
    endtask

    task automatic fillWords(input logic m, input int first, input int last);
        memTypesPkg::Addr a;
        for (int w = first; w < last; w++) begin
            a = memTypesPkg::Addr'(w * 4);
            issue(m, 1'b1, a, memTypesPkg::DataAccess_Word, 1'b0, fillWord(a));
        end
        dropRequest(m);
    endtask

    task automatic runRandom(input logic m, input int count);
        logic [31:0]            r;
        logic                   isWrite;
        logic                   uns;
        memTypesPkg::DataAccess acc;
        memTypesPkg::Addr       a;
        for (int i = 0; i < count; i++) begin
            r = randBits(3);
            isWrite = r[2];
            acc = (r[1:0] == 2'b11) ? memTypesPkg::DataAccess_Word
                                    : memTypesPkg::DataAccess'(r[1:0]);
            // Half the accesses hit eight hot words
            r = randBits(1);
            a = r[0] ? randBits(addrBits) : randBits(5);
            a[31:addrBits] = '0;
            r = randBits(1);
            uns = r[0];
            issue(m, isWrite, a, acc, uns, randBits(32));
            r = randBits(2);
            if (r[1:0] == 2'b00) begin
                dropRequest(m);
                @(posedge clock);
                #1;
            end
        end
        dropRequest(m);
    endtask

    // Grants and read returns checked every cycle
    initial begin : checkResponses
        logic [1:0]       req;
        logic [1:0]       rdGranted;
        logic             lastWin;
        logic             win;
        memTypesPkg::Data want;
        lastWin = 1'b1;
        rdGranted = 2'b00;
        forever begin
            @(negedge clock);
            req = {rdIn[1] | wrIn[1], rdIn[0] | wrIn[0]};
            win = (req == 2'b11) ? ~lastWin : req[1];
            checkValue("cpuGrant", 32'(req[0] & ~win), 32'(grant[0]));
            checkValue("dmaGrant", 32'(req[1] & win), 32'(grant[1]));
            checkValue("cpuRdValid", 32'(rdGranted[0]), 32'(rdValid[0]));
            checkValue("dmaRdValid", 32'(rdGranted[1]), 32'(rdValid[1]));
            if (rdValid[0]) begin
                want = cpuExpected.pop_front();
                checkValue("cpuRdData", want, rdData[0]);
            end
            if (rdValid[1]) begin
                want = dmaExpected.pop_front();
                checkValue("dmaRdData", want, rdData[1]);
            end
            if (req != 2'b00) begin
                lastWin = win;
            end
            rdGranted = {rdIn[1] & win, rdIn[0] & ~win};
        end
    end

    initial begin : stimulus
        int waited;
        rstN = 1'b0;
        rdIn = '{1'b0, 1'b0};
        wrIn = '{1'b0, 1'b0};
        addrIn = '{32'h0, 32'h0};
        accIn = '{memTypesPkg::DataAccess_Word, memTypesPkg::DataAccess_Word};
        unsIn = '{1'b0, 1'b0};
        wrDataIn = '{32'h0, 32'h0};
        repeat (5) @(posedge clock);
        #1;
        rstN = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        // Both masters start together, so the first contest follows reset
        fork
            fillWords(1'b0, 0, memWords / 2);
            fillWords(1'b1, memWords / 2, memWords);
        join
        fork
            runRandom(1'b0, randomOps);
            runRandom(1'b1, randomOps);
        join
        for (int w = 0; w < 8; w++) begin
            issue(1'b0, 1'b0, memTypesPkg::Addr'(w * 4), memTypesPkg::DataAccess_Word,
                  1'b0, '0);
        end
        dropRequest(1'b0);
        waited = 0;
        while (cpuExpected.size() != 0 || dmaExpected.size() != 0) begin
            waited++;
            if (waited > grantTimeout) begin
                stopWithFailure("read data never came back for a granted read");
            end
            @(negedge clock);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: sharedDataMemory.f
design/memTypesPkg.sv
design/arbTypesPkg.sv
design/dataBus.sv
design/ramByteLane.sv
design/dataMemory.sv
design/busArbiter.sv
design/sharedDataMemory.sv
verif/sharedDataMemoryTb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module sharedDataMemoryTb -f sharedDataMemory.f
./obj_dir/VsharedDataMemoryTb | tee sim.log
if grep -qx "TB PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
